// File: uart_link.f
+incdir+src
src/uart_link_pkg.sv
src/uart_rx.sv
src/uart_tx.sv
src/command_handler.sv
src/uart_link_top.sv
bench/uart_link_tb.sv

// File: bench/uart_link_tb.sv
// Testbench for the serial command link top level
// Serial stimulus, reply decoder, LED model with reference function, watchdog

`include "uart_link_params.svh"

module uart_link_tb;

    localparam int CLK_PERIOD = 20;
    localparam int CLKS       = 8;                      // Short bit time for simulation
    localparam int PAR        = 1;                      // Even parity on the link
    localparam int LED_WAIT   = 4;                      // Clocks after frame end for LEDs
    localparam int NUM_FRAMES = 308;                    // Directed frames plus random run
    localparam int WATCHDOG_TIME = NUM_FRAMES * 2 * (10 + PAR) * CLKS * CLK_PERIOD + 1000;

    // Expected state of the link after each frame
    typedef struct packed {
        logic                      red;
        logic                      green;
        logic                      blue;
        uart_link_pkg::uart_byte_t cnt;                 // Last reply value
        logic                      reply;               // This frame asks for a reply
    } model_t;

    logic clk;
    logic reset;
    logic rx;
    logic tx;
    logic led_red;
    logic led_green;
    logic led_blue;

    model_t                    model;
    uart_link_pkg::uart_byte_t exp_replies[$];          // Replies still to come on tx
    int                        error_count = 0;
    logic                      saw_wrap = 1'b0;         // Counter went FF to 00
    logic [31:0]               lcg_state = 32'h71b2_c124;
    event                      frame_done;

    uart_link_top #(
        .CLKS_PER_BIT(CLKS),
        .PARITY      (PAR)
    ) dut_i (
        .clk      (clk),
        .reset    (reset),
        .rx       (rx),
        .tx       (tx),
        .led_red  (led_red),
        .led_green(led_green),
        .led_blue (led_blue)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // ******************************
    // Reference model and checks
    // ******************************

    function automatic model_t model_step(input model_t prev, input uart_link_pkg::uart_byte_t data,
                                          input logic bad);
        model_t nxt;
        nxt       = prev;
        nxt.reply = 1'b0;
        if (bad) begin
            nxt.blue = `UART_LINK_LED_ON;               // Red, green and counter kept
        end else begin
            nxt.blue = `UART_LINK_LED_OFF;
            if (data == `UART_LINK_CMD_TOGGLE) begin
                nxt.red   = `UART_LINK_LED_ON;
                nxt.green = `UART_LINK_LED_OFF;
            end else if (data == `UART_LINK_CMD_ACK) begin
                nxt.red   = `UART_LINK_LED_OFF;
                nxt.green = `UART_LINK_LED_ON;
            end else begin
                nxt.red   = `UART_LINK_LED_OFF;
                nxt.green = `UART_LINK_LED_OFF;
                nxt.cnt   = prev.cnt + 8'h01;           // Wraps at 8 bits
                nxt.reply = 1'b1;
            end
        end
        return nxt;
    endfunction

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    task automatic stop_with_failure();
        $display("Finished with errors");
        $fatal(1);
    endtask

    task automatic check_byte(input uart_link_pkg::uart_byte_t got,
                              input uart_link_pkg::uart_byte_t exp, input string what);
        if (got !== exp) begin
            error_count++;
            $display("[FAIL] %0t: %s is %02h, expected %02h", $time, what, got, exp);
            stop_with_failure();
        end
    endtask

    task automatic check_led(input logic got, input logic exp, input string name);
        if (got !== exp) begin
            error_count++;
            $display("[FAIL] %0t: %s pin is %b, expected %b", $time, name, got, exp);
            stop_with_failure();
        end
    endtask

    task automatic check_line_bit(input logic got, input logic exp, input string what);
        if (got !== exp) begin
            error_count++;
            $display("[FAIL] %0t: %s is %b, expected %b", $time, what, got, exp);
            stop_with_failure();
        end
    endtask

    // ******************************
    // Serial stimulus
    // ******************************

    task automatic drive_bit(input logic b);
        rx = b;
        repeat (CLKS) @(negedge clk);                   // One bit time
    endtask

    task automatic line_idle(input int bit_times);
        rx = 1'b1;
        repeat (bit_times * CLKS) @(negedge clk);
    endtask

    // Starts and ends on a falling edge
    task automatic send_frame(input uart_link_pkg::uart_byte_t data, input logic bad_parity,
                              input logic bad_stop);
        logic par;
        par = (^data) ^ bad_parity;                     // Even parity unless a bad bit is wanted
        drive_bit(1'b0);
        for (int i = 0; i < 8; i++)
            drive_bit(data[i]);                         // LSB first
        if (PAR != 0)
            drive_bit(par);
        drive_bit(!bad_stop);
        model = model_step(model, data, (bad_parity && PAR != 0) || bad_stop);
        if (model.reply) begin
            exp_replies.push_back(model.cnt);
            if (model.cnt == 8'h00)
                saw_wrap = 1'b1;
        end
        -> frame_done;
    endtask

    task automatic wait_replies();
        wait (exp_replies.size() == 0);
        @(negedge clk);                                 // Back onto the drive edge
    endtask

    // ******************************
    // Reply decoder and LED checker
    // ******************************

    initial begin : reply_decoder
        uart_link_pkg::uart_byte_t data;
        uart_link_pkg::uart_byte_t exp_byte;
        logic                      par_bit;
        @(negedge reset);
        forever begin
            @(negedge tx);                              // Start bit edge
            repeat (CLKS / 2) @(negedge clk);
            check_line_bit(tx, 1'b0, "reply start bit");
            for (int i = 0; i < 8; i++) begin
                repeat (CLKS) @(negedge clk);
                data[i] = tx;
            end
            par_bit = 1'b0;
            if (PAR != 0) begin
                repeat (CLKS) @(negedge clk);
                par_bit = tx;
            end
            repeat (CLKS) @(negedge clk);
            check_line_bit(tx, 1'b1, "reply stop bit");
            if (exp_replies.size() == 0) begin
                error_count++;
                $display("Reply byte %02h appeared on tx although no reply was expected", data);
                stop_with_failure();
            end else begin
                exp_byte = exp_replies.pop_front();
                check_byte(data, exp_byte, "reply byte");
                if (PAR != 0)
                    check_line_bit(par_bit, ^exp_byte, "reply parity bit");
            end
        end
    end

    initial begin : led_checker
        model_t snap;
        forever begin
            @(frame_done);
            snap = model;                               // Stable until the next frame ends
            repeat (LED_WAIT) @(negedge clk);
            check_led(led_red, snap.red, "led_red");
            check_led(led_green, snap.green, "led_green");
            check_led(led_blue, snap.blue, "led_blue");
        end
    end

    initial begin : watchdog
        #(WATCHDOG_TIME);
        $display("Watchdog expired, the simulation hung waiting on the DUT");
        stop_with_failure();
    end

    // ******************************
    // Test sequence
    // ******************************

    initial begin : main_sequence
        uart_link_pkg::uart_byte_t data;
        reset = 1'b1;
        rx    = 1'b1;
        model = '{red: `UART_LINK_LED_OFF, green: `UART_LINK_LED_OFF,
                  blue: `UART_LINK_LED_OFF, cnt: 8'h00, reply: 1'b0};
        repeat (8) @(negedge clk);
        reset = 1'b0;

        // Quiet line after reset with no reply and dark LEDs
        repeat (30 * CLKS) begin
            @(negedge clk);
            check_line_bit(tx, 1'b1, "idle tx line");
        end
        check_led(led_red, `UART_LINK_LED_OFF, "led_red");
        check_led(led_green, `UART_LINK_LED_OFF, "led_green");
        check_led(led_blue, `UART_LINK_LED_OFF, "led_blue");

        // Command codes
        send_frame(`UART_LINK_CMD_TOGGLE, 1'b0, 1'b0);
        send_frame(`UART_LINK_CMD_ACK, 1'b0, 1'b0);

        // Plain bytes give replies 01, 02, 03
        send_frame(8'h00, 1'b0, 1'b0);
        send_frame(8'hA5, 1'b0, 1'b0);
        send_frame(8'h7E, 1'b0, 1'b0);
        wait_replies();

        // Parity and stop errors followed by a good frame that clears blue
        send_frame(8'h12, 1'b1, 1'b0);
        line_idle(2);
        send_frame(8'h34, 1'b0, 1'b1);
        line_idle(2);                                   // Stop bit back high
        send_frame(8'h55, 1'b0, 1'b0);
        wait_replies();

        // Random run with a command code every 16th frame to keep the reply backlog short
        for (int i = 0; i < 300; i++) begin
            lcg_state = lcg_next(lcg_state);
            if (i % 16 == 15)
                data = (i % 32 == 15) ? `UART_LINK_CMD_TOGGLE : `UART_LINK_CMD_ACK;
            else if (lcg_state[29:24] == 6'd0)
                data = `UART_LINK_CMD_TOGGLE;
            else if (lcg_state[29:24] == 6'd1)
                data = `UART_LINK_CMD_ACK;
            else
                data = lcg_state[23:16];
            send_frame(data, 1'b0, 1'b0);
        end
        wait_replies();
        line_idle(30);                                  // Catch any late extra reply

        if (!saw_wrap) begin
            error_count++;
            $display("The random run never wrapped the reply counter from FF to 00");
        end

        if (error_count == 0) begin
            $display("Finished with no errors");
            $finish;
        end else begin
            stop_with_failure();
        end
    end

endmodule

// File: src/uart_link_top.sv
// Top level of the serial command link
// Receiver, command handler and transmitter wired together

`include "uart_link_params.svh"

module uart_link_top #(
    parameter int CLKS_PER_BIT = `UART_LINK_CLKS_PER_BIT,
    parameter int PARITY       = `UART_LINK_PARITY
) (
    input  logic clk,
    input  logic reset,
    input  logic rx,
    output logic tx,
    output logic led_red,
    output logic led_green,
    output logic led_blue
);

    uart_link_pkg::uart_byte_t rx_byte;     // Receiver to handler
    logic                      rx_done;
    logic                      frame_error;
    uart_link_pkg::uart_byte_t tx_byte;     // Handler to transmitter
    logic                      start_tx;
    logic                      tx_busy;

    // ******************************
    // Serial in
    // ******************************

    uart_rx #(
        .CLKS_PER_BIT(CLKS_PER_BIT),
        .PARITY      (PARITY)
    ) rx_i (
        .clk        (clk),
        .reset      (reset),
        .rx         (rx),
        .rx_byte    (rx_byte),
        .rx_done    (rx_done),
        .frame_error(frame_error)
    );

    command_handler handler_i (
        .clk        (clk),
        .reset      (reset),
        .rx_byte    (rx_byte),
        .rx_done    (rx_done),
        .frame_error(frame_error),
        .tx_busy    (tx_busy),
        .tx_byte    (tx_byte),
        .start_tx   (start_tx),
        .led_red    (led_red),
        .led_green  (led_green),
        .led_blue   (led_blue)
    );

    // Replies go back on the same link settings
    uart_tx #(
        .CLKS_PER_BIT(CLKS_PER_BIT),
        .PARITY      (PARITY)
    ) tx_i (
        .clk     (clk),
        .reset   (reset),
        .tx_byte (tx_byte),
        .start_tx(start_tx),
        .tx      (tx),
        .tx_busy (tx_busy)
    );

endmodule

// File: src/command_handler.sv
// Command decoder for received bytes, LED drive and reply counter
// One-entry pending slot holds a reply while the transmitter is busy

`include "uart_link_params.svh"

module command_handler (
    input  logic                      clk,
    input  logic                      reset,
    input  uart_link_pkg::uart_byte_t rx_byte,
    input  logic                      rx_done,
    input  logic                      frame_error,
    input  logic                      tx_busy,
    output uart_link_pkg::uart_byte_t tx_byte,
    output logic                      start_tx,
    output logic                      led_red,
    output logic                      led_green,
    output logic                      led_blue
);

    uart_link_pkg::uart_byte_t reply_cnt;   // Last reply value sent or queued
    uart_link_pkg::uart_byte_t next_cnt;    // Wraps FF to 00
    logic                      new_reply;   // Good byte that is not a command
    logic                      pending;     // tx_byte waits for the transmitter

    // ******************************
    // Decode
    // ******************************

    assign new_reply = rx_done
                    && (rx_byte != `UART_LINK_CMD_TOGGLE)
                    && (rx_byte != `UART_LINK_CMD_ACK);
    assign next_cnt  = reply_cnt + 1'b1;

    // Fires in the first cycle the transmitter is free
    assign start_tx  = pending && !tx_busy;

    always_ff @(posedge clk) begin
        if (reset) begin
            led_red   <= `UART_LINK_LED_OFF;
            led_green <= `UART_LINK_LED_OFF;
            led_blue  <= `UART_LINK_LED_OFF;
            reply_cnt <= '0;
            pending   <= 1'b0;
        end else begin
            if (rx_done) begin
                led_blue <= `UART_LINK_LED_OFF;   // Any good frame clears the error
                case (rx_byte)
                    `UART_LINK_CMD_TOGGLE: begin
                        led_red   <= `UART_LINK_LED_ON;
                        led_green <= `UART_LINK_LED_OFF;
                    end
                    `UART_LINK_CMD_ACK: begin
                        led_red   <= `UART_LINK_LED_OFF;
                        led_green <= `UART_LINK_LED_ON;
                    end
                    default: begin
                        led_red   <= `UART_LINK_LED_OFF;
                        led_green <= `UART_LINK_LED_OFF;
                        reply_cnt <= next_cnt;
                    end
                endcase
            end
            if (frame_error)
                led_blue <= `UART_LINK_LED_ON;    // Red, green and counter untouched

            // A new reply wins over the handoff in the same cycle
            if (new_reply)
                pending <= 1'b1;
            else if (start_tx)
                pending <= 1'b0;
        end
    end

    // Reply byte, newer value overwrites one still waiting
    always_ff @(posedge clk) begin
        if (new_reply)
            tx_byte <= next_cnt;
    end

    // busy rises the cycle after start, which closes the pulse
    handler_start_single: assert property (
        @(posedge clk) disable iff (reset) start_tx |=> !start_tx
    );

endmodule

// File: src/uart_tx.sv
// UART transmitter, start bit, 8 data bits LSB first, optional even parity, stop bit
// Busy level covers the whole frame

`include "uart_link_params.svh"

module uart_tx #(
    parameter int CLKS_PER_BIT = `UART_LINK_CLKS_PER_BIT,
    parameter int PARITY       = `UART_LINK_PARITY
) (
    input  logic                      clk,
    input  logic                      reset,
    input  uart_link_pkg::uart_byte_t tx_byte,
    input  logic                      start_tx,
    output logic                      tx,
    output logic                      tx_busy
);

    localparam uart_link_pkg::clk_count_t BIT_LAST =
        uart_link_pkg::clk_count_t'(CLKS_PER_BIT - 1);
    localparam uart_link_pkg::bit_count_t LAST_DATA_BIT = uart_link_pkg::bit_count_t'(7);

    uart_link_pkg::tx_state_t  state;
    uart_link_pkg::clk_count_t clk_cnt;     // Clocks inside current bit
    uart_link_pkg::bit_count_t bit_idx;
    uart_link_pkg::uart_byte_t shift_reg;   // Bit 0 is on the line during data
    logic                      parity_bit;  // Even parity of the latched byte

    // ******************************
    // Frame FSM
    // ******************************

    // tx is registered and loaded with the next bit on every transition,
    // so each bit starts exactly on a state change
    always_ff @(posedge clk) begin
        if (reset) begin
            state   <= uart_link_pkg::tx_idle;
            clk_cnt <= '0;
            bit_idx <= '0;
            tx      <= 1'b1;                // Idle line
            tx_busy <= 1'b0;
        end else begin
            case (state)
                uart_link_pkg::tx_idle: begin
                    clk_cnt <= '0;
                    bit_idx <= '0;
                    if (start_tx) begin
                        tx      <= 1'b0;    // Start bit from the next cycle
                        tx_busy <= 1'b1;
                        state   <= uart_link_pkg::tx_start;
                    end
                end
                uart_link_pkg::tx_start: begin
                    if (clk_cnt == BIT_LAST) begin
                        clk_cnt <= '0;
                        tx      <= shift_reg[0];
                        state   <= uart_link_pkg::tx_data;
                    end else begin
                        clk_cnt <= clk_cnt + 1'b1;
                    end
                end
                uart_link_pkg::tx_data: begin
                    if (clk_cnt == BIT_LAST) begin
                        clk_cnt <= '0;
                        if (bit_idx == LAST_DATA_BIT) begin
                            tx    <= (PARITY != 0) ? parity_bit : 1'b1;
                            state <= (PARITY != 0) ? uart_link_pkg::tx_parity
                                                   : uart_link_pkg::tx_stop;
                        end else begin
                            bit_idx <= bit_idx + 1'b1;
                            tx      <= shift_reg[1];      // Next bit before the shift
                        end
                    end else begin
                        clk_cnt <= clk_cnt + 1'b1;
                    end
                end
                uart_link_pkg::tx_parity: begin
                    if (clk_cnt == BIT_LAST) begin
                        clk_cnt <= '0;
                        tx      <= 1'b1;    // Stop bit
                        state   <= uart_link_pkg::tx_stop;
                    end else begin
                        clk_cnt <= clk_cnt + 1'b1;
                    end
                end
                uart_link_pkg::tx_stop: begin
                    if (clk_cnt == BIT_LAST) begin
                        clk_cnt <= '0;
                        tx_busy <= 1'b0;    // Low in the cycle after the stop bit
                        state   <= uart_link_pkg::tx_idle;
                    end else begin
                        clk_cnt <= clk_cnt + 1'b1;
                    end
                end
                default: state <= uart_link_pkg::tx_idle;
            endcase
        end
    end

    // Data path, latched on start and shifted once per data bit
    always_ff @(posedge clk) begin
        if (state == uart_link_pkg::tx_idle && start_tx) begin
            shift_reg  <= tx_byte;
            parity_bit <= ^tx_byte;
        end else if (state == uart_link_pkg::tx_data && clk_cnt == BIT_LAST) begin
            shift_reg  <= {1'b0, shift_reg[7:1]};
        end
    end

    // Handler must wait for the previous frame to finish
    tx_no_start_when_busy: assert property (
        @(posedge clk) disable iff (reset) start_tx |-> !tx_busy
    );

    tx_idle_line_high: assert property (
        @(posedge clk) disable iff (reset) (state == uart_link_pkg::tx_idle) |-> tx
    );

endmodule

// File: src/uart_rx.sv
// UART receiver with a 2-flop line synchronizer and mid-bit sampling
// Optional even parity, stop bit check, good byte or frame error strobe

`include "uart_link_params.svh"

module uart_rx #(
    parameter int CLKS_PER_BIT = `UART_LINK_CLKS_PER_BIT,
    parameter int PARITY       = `UART_LINK_PARITY
) (
    input  logic                      clk,
    input  logic                      reset,
    input  logic                      rx,
    output uart_link_pkg::uart_byte_t rx_byte,
    output logic                      rx_done,
    output logic                      frame_error
);

    // Sample points inside a bit
    localparam uart_link_pkg::clk_count_t HALF_BIT =
        uart_link_pkg::clk_count_t'((CLKS_PER_BIT - 1) / 2);
    localparam uart_link_pkg::clk_count_t BIT_LAST =
        uart_link_pkg::clk_count_t'(CLKS_PER_BIT - 1);
    localparam uart_link_pkg::bit_count_t LAST_DATA_BIT = uart_link_pkg::bit_count_t'(7);

    logic                      rx_meta;     // First synchronizer stage
    logic                      rx_sync;     // Line as seen by the FSM
    uart_link_pkg::rx_state_t  state;
    uart_link_pkg::clk_count_t clk_cnt;     // Clocks inside current bit
    uart_link_pkg::bit_count_t bit_idx;     // Data bit index
    uart_link_pkg::uart_byte_t shift_reg;   // Data bits shift in from the top
    logic                      parity_acc;  // XOR of data bits seen so far
    logic                      parity_bad;  // Parity bit disagreed

    // ******************************
    // Line synchronizer
    // ******************************

    always_ff @(posedge clk) begin
        if (reset) begin
            rx_meta <= 1'b1;                // Line idles high
            rx_sync <= 1'b1;
        end else begin
            rx_meta <= rx;
            rx_sync <= rx_meta;
        end
    end

    // ******************************
    // Frame FSM
    // ******************************

    always_ff @(posedge clk) begin
        if (reset) begin
            state       <= uart_link_pkg::rx_idle;
            clk_cnt     <= '0;
            bit_idx     <= '0;
            parity_acc  <= 1'b0;
            parity_bad  <= 1'b0;
            rx_done     <= 1'b0;
            frame_error <= 1'b0;
        end else begin
            rx_done     <= 1'b0;            // Strobes last one cycle
            frame_error <= 1'b0;
            case (state)
                uart_link_pkg::rx_idle: begin
                    clk_cnt    <= '0;
                    bit_idx    <= '0;
                    parity_acc <= 1'b0;
                    parity_bad <= 1'b0;
                    if (!rx_sync)           // Falling edge, possible start bit
                        state <= uart_link_pkg::rx_start;
                end
                uart_link_pkg::rx_start: begin
                    if (clk_cnt == HALF_BIT) begin
                        clk_cnt <= '0;      // From here on, each full bit lands mid-bit
                        // A glitch shorter than half a bit drops back to idle
                        state   <= rx_sync ? uart_link_pkg::rx_idle : uart_link_pkg::rx_data;
                    end else begin
                        clk_cnt <= clk_cnt + 1'b1;
                    end
                end
                uart_link_pkg::rx_data: begin
                    if (clk_cnt == BIT_LAST) begin
                        clk_cnt    <= '0;
                        shift_reg  <= {rx_sync, shift_reg[7:1]};  // LSB first
                        parity_acc <= parity_acc ^ rx_sync;
                        if (bit_idx == LAST_DATA_BIT) begin
                            bit_idx <= '0;
                            state   <= (PARITY != 0) ? uart_link_pkg::rx_parity
                                                     : uart_link_pkg::rx_stop;
                        end else begin
                            bit_idx <= bit_idx + 1'b1;
                        end
                    end else begin
                        clk_cnt <= clk_cnt + 1'b1;
                    end
                end
                uart_link_pkg::rx_parity: begin
                    if (clk_cnt == BIT_LAST) begin
                        clk_cnt    <= '0;
                        parity_bad <= rx_sync ^ parity_acc;  // Even parity over data
                        state      <= uart_link_pkg::rx_stop;
                    end else begin
                        clk_cnt <= clk_cnt + 1'b1;
                    end
                end
                uart_link_pkg::rx_stop: begin
                    if (clk_cnt == BIT_LAST) begin
                        clk_cnt     <= '0;
                        rx_done     <= rx_sync && !parity_bad;
                        frame_error <= !rx_sync || parity_bad;
                        // Back to idle at mid stop bit, next start edge is caught
                        state       <= uart_link_pkg::rx_idle;
                    end else begin
                        clk_cnt <= clk_cnt + 1'b1;
                    end
                end
                default: state <= uart_link_pkg::rx_idle;
            endcase
        end
    end

    // Shift register holds still until the next frame's first data bit
    assign rx_byte = shift_reg;

    // A frame ends in exactly one of the two strobes
    rx_strobes_exclusive: assert property (
        @(posedge clk) disable iff (reset) !(rx_done && frame_error)
    );

endmodule

// File: src/uart_link_pkg.sv
// Types shared by the receiver, transmitter and command handler
// Byte, bit index and clock counter widths, FSM state encodings

package uart_link_pkg;

    typedef logic [7:0]  uart_byte_t;   // One data byte on the line
    typedef logic [3:0]  bit_count_t;   // Bit index inside a frame
    typedef logic [15:0] clk_count_t;   // Clocks elapsed inside one bit

    // Receiver FSM
    typedef enum logic [2:0] {
        rx_idle,                        // Line high, waiting for a falling edge
        rx_start,                       // Confirming start bit at half a bit
        rx_data,                        // Eight data bits, LSB first
        rx_parity,                      // Optional even parity bit
        rx_stop                         // Stop bit must read 1
    } rx_state_t;

    // Transmitter FSM
    typedef enum logic [2:0] {
        tx_idle,
        tx_start,
        tx_data,
        tx_parity,
        tx_stop
    } tx_state_t;

endpackage

// File: src/uart_link_params.svh
// Shared constants for the serial command link
// Command codes, default bit timing and parity, LED pin levels

`ifndef UART_LINK_PARAMS_SVH
`define UART_LINK_PARAMS_SVH

// Command bytes from the host
`define UART_LINK_CMD_TOGGLE 8'h9D  // Lights red
`define UART_LINK_CMD_ACK    8'h3C  // Lights green

// Serial timing, 48 MHz clock at 6 Mbaud
`define UART_LINK_CLKS_PER_BIT 8

// 0 = no parity bit, 1 = even parity
`define UART_LINK_PARITY 1'b0

// Board LEDs are active low
`define UART_LINK_LED_ON  1'b0
`define UART_LINK_LED_OFF 1'b1

`endif
